/* src/mat_mult_config.svh */
// matrix multiply sizes, lane count and readout credit limit
`ifndef MAT_MULT_CONFIG_SVH
`define MAT_MULT_CONFIG_SVH

// element widths
`define MM_DATA_WIDTH   8
`define MM_RESULT_WIDTH 20

// matrix shape: A is MM_A_ROWS x MM_INNER, B is MM_INNER x MM_B_COLS
`define MM_INNER        4
`define MM_A_ROWS       4
`define MM_B_COLS       4

// parallel dot-product lanes, must divide MM_B_COLS
`define MM_LANES        2
`define MM_CREDIT_MAX   4

`endif

/* src/mat_mult_pkg.sv */
// shared element, operand, tag and result row types for the matrix multiplier
`include "mat_mult_config.svh"

package mat_mult_pkg;

    typedef logic [`MM_DATA_WIDTH-1:0]   elem_t;
    typedef logic [`MM_RESULT_WIDTH-1:0] sum_t;

    // one A row or one B column, element 0 in the low bits
    typedef elem_t [`MM_INNER-1:0] vector_t;

    typedef logic [$clog2(`MM_A_ROWS)-1:0] row_idx_t;
    typedef logic [$clog2(`MM_B_COLS)-1:0] col_idx_t;
    // at least one bit even with a single column group
    typedef logic [((`MM_B_COLS / `MM_LANES) > 1 ?
                    $clog2(`MM_B_COLS / `MM_LANES) : 1)-1:0] group_idx_t;

    typedef struct packed {
        logic     a_write;
        logic     b_write;
        row_idx_t addr;
        vector_t  data;
    } load_cmd_t;

    typedef struct packed {
        logic       valid;
        row_idx_t   row;
        group_idx_t group;
        logic       last;
    } fetch_tag_t;

    typedef struct packed {
        row_idx_t                row;
        sum_t [`MM_B_COLS-1:0]   sums;
    } result_row_t;

endpackage

/* src/operand_store.sv */
// operand storage for A rows and B columns with a registered fetch port
`timescale 1ns/1ps
`include "mat_mult_config.svh"

module operand_store
    import mat_mult_pkg::*;
(
    input  logic                    clk,
    input  load_cmd_t               load,
    input  logic                    load_enable,
    input  fetch_tag_t              fetch,
    output vector_t                 a_row,
    output vector_t [`MM_B_COLS-1:0] b_cols,
    output fetch_tag_t              tag
);

    // A is kept row-wise, B column-wise, so one entry is one dot-product operand
    vector_t                  a_mem [`MM_A_ROWS];
    vector_t [`MM_B_COLS-1:0] b_mem;

    logic a_we;
    logic b_we;

    // the load port shares one address between the two stores
    assign a_we = load_enable && load.a_write;
    assign b_we = load_enable && load.b_write;

    always_ff @(posedge clk) begin
        if (a_we) begin
            a_mem[load.addr] <= load.data;
        end
    end

    always_ff @(posedge clk) begin
        if (b_we) begin
            b_mem[col_idx_t'(load.addr)] <= load.data;
        end
    end

    // operands and the step identity leave together one cycle after fetch
    always_ff @(posedge clk) begin
        a_row  <= a_mem[fetch.row];
        b_cols <= b_mem;
    end

    always_ff @(posedge clk) begin
        tag <= fetch;
    end

endmodule

/* src/dot_product_lane.sv */
// one dot-product lane: A row times B column, adder tree, registered sum
`timescale 1ns/1ps
`include "mat_mult_config.svh"

module dot_product_lane
    import mat_mult_pkg::*;
(
    input  logic    clk,
    input  vector_t a_row,
    input  vector_t b_col,
    output sum_t    sum
);

    // tree leaves rounded up to a power of two, unused leaves read zero
    localparam int LEAVES = 1 << $clog2(`MM_INNER);
    localparam int NODES  = 2 * LEAVES - 1;

    // heap layout, node 0 is the root and node n has children 2n+1 and 2n+2
    sum_t node [NODES];

    always_comb begin
        for (int k = 0; k < LEAVES; k++) begin
            if (k < `MM_INNER) begin
                node[LEAVES - 1 + k] = sum_t'(a_row[k]) * sum_t'(b_col[k]);
            end else begin
                node[LEAVES - 1 + k] = '0;
            end
        end
        // sums wrap at the result width
        for (int n = LEAVES - 2; n >= 0; n--) begin
            node[n] = node[2 * n + 1] + node[2 * n + 2];
        end
    end

    always_ff @(posedge clk) begin
        sum <= node[0];
    end

endmodule

/* src/mat_mult_sequencer.sv */
// phase FSM: gates loads, steps row and column group fetches, starts readout
`timescale 1ns/1ps
`include "mat_mult_config.svh"

module mat_mult_sequencer
    import mat_mult_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       start,
    input  logic       read,
    input  logic       compute_done,
    input  logic       read_done,
    output logic       load_enable,
    output fetch_tag_t fetch,
    output logic       read_go
);

    localparam int GROUPS = `MM_B_COLS / `MM_LANES;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPUTE,
        ST_DRAIN,
        ST_READOUT
    } state_t;

    state_t     state;
    row_idx_t   row_cnt;
    group_idx_t grp_cnt;
    logic       last_row;
    logic       last_grp;

    assign last_row = (row_cnt == row_idx_t'(`MM_A_ROWS - 1));
    assign last_grp = (grp_cnt == group_idx_t'(GROUPS - 1));

    // host access to the operand stores only between runs
    assign load_enable = (state == ST_IDLE);

    // start wins over read when both arrive in the same idle cycle
    assign read_go = (state == ST_IDLE) && read && !start;

    // one step per cycle in row-major order
    always_comb begin
        fetch.valid = (state == ST_COMPUTE);
        fetch.row   = row_cnt;
        fetch.group = grp_cnt;
        fetch.last  = last_row && last_grp;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= ST_IDLE;
            row_cnt <= '0;
            grp_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state   <= ST_COMPUTE;
                        row_cnt <= '0;
                        grp_cnt <= '0;
                    end else if (read) begin
                        state <= ST_READOUT;
                    end
                end
                ST_COMPUTE: begin
                    if (last_grp) begin
                        grp_cnt <= '0;
                        row_cnt <= row_cnt + 1'b1;
                    end else begin
                        grp_cnt <= grp_cnt + 1'b1;
                    end
                    if (last_row && last_grp) begin
                        state <= ST_DRAIN;
                    end
                end
                // steps still in the operand, lane and merge stages
                ST_DRAIN: begin
                    if (compute_done) begin
                        state <= ST_IDLE;
                    end
                end
                ST_READOUT: begin
                    if (read_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* src/result_store.sv */
// result row assembly, result memory, and credit-controlled row readout
`timescale 1ns/1ps
`include "mat_mult_config.svh"

module result_store
    import mat_mult_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,
    input  fetch_tag_t             tag,
    input  sum_t [`MM_LANES-1:0]   lane_sums,
    input  logic                   read_go,
    input  logic                   read_credit,
    output logic                   compute_done,
    output logic                   read_done,
    output logic                   result_valid,
    output result_row_t            result
);

    localparam int GROUPS   = `MM_B_COLS / `MM_LANES;
    localparam int CREDIT_W = $clog2(`MM_CREDIT_MAX + 1);

    fetch_tag_t              tag_q;
    sum_t [`MM_B_COLS-1:0]   row_buf;
    sum_t [`MM_B_COLS-1:0]   merged;
    sum_t [`MM_B_COLS-1:0]   res_mem [`MM_A_ROWS];
    logic                    row_end;

    logic [CREDIT_W-1:0]     credit_cnt;
    logic                    rd_active;
    row_idx_t                rd_ptr;
    logic                    issue;

    // lane sums lag the operand tag by the lane register
    always_ff @(posedge clk) begin
        if (!resetn) begin
            tag_q <= '0;
        end else begin
            tag_q <= tag;
        end
    end

    // drop this group's lane sums into their columns of the row
    always_comb begin
        merged = row_buf;
        for (int i = 0; i < `MM_LANES; i++) begin
            merged[col_idx_t'(int'(tag_q.group) * `MM_LANES + i)] = lane_sums[i];
        end
    end

    assign row_end = (tag_q.group == group_idx_t'(GROUPS - 1));

    always_ff @(posedge clk) begin
        if (tag_q.valid) begin
            row_buf <= merged;
            if (row_end) begin
                res_mem[tag_q.row] <= merged;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            compute_done <= 1'b0;
        end else begin
            compute_done <= tag_q.valid && tag_q.last;
        end
    end

    // one row per cycle while the host holds credit
    assign issue = rd_active && (credit_cnt != '0);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            credit_cnt <= '0;
        end else if (read_credit && !issue) begin
            if (credit_cnt != CREDIT_W'(`MM_CREDIT_MAX)) begin
                credit_cnt <= credit_cnt + 1'b1;
            end
        end else if (issue && !read_credit) begin
            credit_cnt <= credit_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_active <= 1'b0;
            rd_ptr    <= '0;
        end else if (read_go) begin
            rd_active <= 1'b1;
            rd_ptr    <= '0;
        end else if (issue) begin
            rd_ptr <= rd_ptr + 1'b1;
            if (rd_ptr == row_idx_t'(`MM_A_ROWS - 1)) begin
                rd_active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        result.row  <= rd_ptr;
        result.sums <= res_mem[rd_ptr];
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            result_valid <= 1'b0;
            read_done    <= 1'b0;
        end else begin
            result_valid <= issue;
            // the cycle after the final row is presented
            read_done    <= result_valid && (result.row == row_idx_t'(`MM_A_ROWS - 1));
        end
    end

endmodule

/* src/mat_mult_top.sv */
// matrix multiply accelerator top: sequencer, operand store, lanes, result store
`timescale 1ns/1ps
`include "mat_mult_config.svh"

module mat_mult_top
    import mat_mult_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  load_cmd_t   load,
    input  logic        start,
    input  logic        read,
    input  logic        read_credit,
    output logic        done,
    output logic        read_done,
    output logic        result_valid,
    output result_row_t result
);

    logic                     load_enable;
    logic                     read_go;
    logic                     compute_done;
    fetch_tag_t               fetch;
    fetch_tag_t               tag;
    vector_t                  a_row;
    vector_t [`MM_B_COLS-1:0] b_cols;
    sum_t [`MM_LANES-1:0]     lane_sums;

    assign done = compute_done;

    mat_mult_sequencer u_sequencer (
        .clk          (clk),
        .resetn       (resetn),
        .start        (start),
        .read         (read),
        .compute_done (compute_done),
        .read_done    (read_done),
        .load_enable  (load_enable),
        .fetch        (fetch),
        .read_go      (read_go)
    );

    operand_store u_operand_store (
        .clk         (clk),
        .load        (load),
        .load_enable (load_enable),
        .fetch       (fetch),
        .a_row       (a_row),
        .b_cols      (b_cols),
        .tag         (tag)
    );

    // lane i works on column group * MM_LANES + i of the current step
    for (genvar i = 0; i < `MM_LANES; i++) begin : gen_lane
        col_idx_t lane_col;

        assign lane_col = col_idx_t'(int'(tag.group) * `MM_LANES + i);

        dot_product_lane u_lane (
            .clk   (clk),
            .a_row (a_row),
            .b_col (b_cols[lane_col]),
            .sum   (lane_sums[i])
        );
    end

    result_store u_result_store (
        .clk          (clk),
        .resetn       (resetn),
        .tag          (tag),
        .lane_sums    (lane_sums),
        .read_go      (read_go),
        .read_credit  (read_credit),
        .compute_done (compute_done),
        .read_done    (read_done),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

/* verif/mat_mult_tb_checks.svh */
// reference product rows and typed result compare tasks for the matrix multiply testbench
`ifndef MAT_MULT_TB_CHECKS_SVH
`define MAT_MULT_TB_CHECKS_SVH

// row r of A times B with each entry wrapped to the result width
function automatic result_row_t ref_row(row_idx_t r);
    result_row_t exp_row;
    longint      acc;
    exp_row.row = r;
    for (int c = 0; c < `MM_B_COLS; c++) begin
        acc = 0;
        for (int k = 0; k < `MM_INNER; k++) begin
            acc += longint'(a_ref[r][k]) * longint'(b_ref[c][k]);
        end
        exp_row.sums[c] = sum_t'(acc);
    end
    return exp_row;
endfunction

task automatic check_sum(string name, sum_t expected, sum_t actual);
    if (actual !== expected) begin
        mismatch_count++;
        $display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
    end
endtask

task automatic check_row_idx(string name, row_idx_t expected, row_idx_t actual);
    if (actual !== expected) begin
        mismatch_count++;
        $display("Mismatch %s row index: expected %0d, actual %0d", name, expected, actual);
    end
endtask

// every column of one result row
task automatic check_row(string name, result_row_t expected, result_row_t actual);
    for (int c = 0; c < `MM_B_COLS; c++) begin
        check_sum($sformatf("%s row %0d col %0d", name, expected.row, c),
                  expected.sums[c], actual.sums[c]);
    end
endtask

task automatic report_error(string what);
    error_count++;
    $display("Error in %s: %s", test_name, what);
endtask

`endif

/* verif/mat_mult_tb.sv */
// testbench for the matrix multiply accelerator: load, compute, credit readout
`timescale 1ns/1ps
`include "mat_mult_config.svh"

module mat_mult_tb
    import mat_mult_pkg::*;
;

    localparam int DONE_TIMEOUT = 100;
    localparam int READ_TIMEOUT = 200;

    logic        clk;
    logic        resetn;
    load_cmd_t   load;
    logic        start;
    logic        read;
    logic        read_credit;
    logic        done;
    logic        read_done;
    logic        result_valid;
    result_row_t result;

    // host copies of the operands, b_ref is kept column-wise like the load port
    elem_t a_ref [`MM_A_ROWS][`MM_INNER];
    elem_t b_ref [`MM_B_COLS][`MM_INNER];

    int          mismatch_count = 0;
    int          error_count = 0;
    bit          timed_out = 1'b0;
    int          done_count = 0;
    int          read_done_count = 0;
    int          valid_count = 0;
    int          credits_granted = 0;
    int          rows_seen = 0;
    bit          reading = 1'b0;
    result_row_t got_rows [`MM_A_ROWS];
    string       test_name = "reset";

    `include "mat_mult_tb_checks.svh"

    mat_mult_top dut0 (
        .clk          (clk),
        .resetn       (resetn),
        .load         (load),
        .start        (start),
        .read         (read),
        .read_credit  (read_credit),
        .done         (done),
        .read_done    (read_done),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // monitor, sampled mid-cycle where the registered outputs are settled
    initial begin
        forever begin
            @(negedge clk);
            if (resetn) begin
                if (done) begin
                    done_count++;
                end
                if (result_valid) begin
                    valid_count++;
                    if (!reading) begin
                        report_error("result_valid outside a readout");
                    end else if (rows_seen >= `MM_A_ROWS) begin
                        report_error("more result rows than the matrix has");
                    end else begin
                        if (valid_count > credits_granted) begin
                            report_error("result row sent without a credit");
                        end
                        check_row_idx(test_name, row_idx_t'(rows_seen), result.row);
                        check_row(test_name, ref_row(row_idx_t'(rows_seen)), result);
                        got_rows[row_idx_t'(rows_seen)] = result;
                        rows_seen++;
                    end
                end
                if (read_done) begin
                    read_done_count++;
                    if (rows_seen != `MM_A_ROWS) begin
                        report_error("read_done before all rows were delivered");
                    end
                    rows_seen = 0;
                end
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic randomize_operands();
        for (int r = 0; r < `MM_A_ROWS; r++) begin
            for (int k = 0; k < `MM_INNER; k++) begin
                a_ref[r][k] = elem_t'($urandom);
            end
        end
        for (int c = 0; c < `MM_B_COLS; c++) begin
            for (int k = 0; k < `MM_INNER; k++) begin
                b_ref[c][k] = elem_t'($urandom);
            end
        end
    endtask

    task automatic write_operands();
        load = '0;
        for (int r = 0; r < `MM_A_ROWS; r++) begin
            load.a_write = 1'b1;
            load.b_write = 1'b0;
            load.addr    = row_idx_t'(r);
            for (int k = 0; k < `MM_INNER; k++) begin
                load.data[k] = a_ref[r][k];
            end
            next_cycle();
        end
        for (int c = 0; c < `MM_B_COLS; c++) begin
            load.a_write = 1'b0;
            load.b_write = 1'b1;
            load.addr    = row_idx_t'(c);
            for (int k = 0; k < `MM_INNER; k++) begin
                load.data[k] = b_ref[c][k];
            end
            next_cycle();
        end
        load = '0;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    task automatic pulse_credit();
        read_credit = 1'b1;
        credits_granted++;
        next_cycle();
        read_credit = 1'b0;
    endtask

    task automatic wait_done(int base);
        int cycles;
        cycles = 0;
        while (done_count == base && cycles < DONE_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (done_count == base) begin
            $display("Timeout in %s: done did not arrive within %0d cycles",
                     test_name, DONE_TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_read_done(int base);
        int cycles;
        cycles = 0;
        while (read_done_count == base && cycles < READ_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (read_done_count == base) begin
            $display("Timeout in %s: read_done did not arrive within %0d cycles",
                     test_name, READ_TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_compute();
        int base;
        base = done_count;
        pulse_start();
        wait_done(base);
    endtask

    // trickle hands out credits one at a time after a stretch with none
    task automatic run_readout(bit trickle);
        int rd_base;
        int held;
        int gap;
        rd_base = read_done_count;
        reading = 1'b1;
        if (!trickle) begin
            repeat (`MM_A_ROWS) pulse_credit();
        end
        read = 1'b1;
        next_cycle();
        read = 1'b0;
        if (trickle) begin
            held = valid_count;
            repeat (20) next_cycle();
            if (valid_count != held) begin
                report_error("result_valid while the host held no credit");
            end
            repeat (`MM_A_ROWS) begin
                gap = int'($urandom % 5);
                repeat (gap) next_cycle();
                pulse_credit();
            end
        end
        wait_read_done(rd_base);
        if (timed_out) begin
            return;
        end
        repeat (4) next_cycle();
        if (read_done_count != rd_base + 1) begin
            report_error("read_done did not pulse exactly once");
        end
        reading = 1'b0;
    endtask

    task automatic test_reset_quiet();
        test_name = "reset_quiet";
        repeat (10) begin
            @(negedge clk);
            if (done || read_done || result_valid) begin
                report_error("output high after reset with no stimulus");
            end
        end
        next_cycle();
    endtask

    task automatic test_random_product();
        test_name = "random_product";
        randomize_operands();
        write_operands();
        run_compute();
        if (timed_out) begin
            return;
        end
        run_readout(1'b0);
    endtask

    task automatic test_credit_backpressure();
        test_name = "credit_backpressure";
        randomize_operands();
        write_operands();
        run_compute();
        if (timed_out) begin
            return;
        end
        run_readout(1'b1);
    endtask

    task automatic test_ignored_during_compute();
        vector_t new_cols [`MM_B_COLS];
        int      base;
        test_name = "ignored_during_compute";
        randomize_operands();
        write_operands();
        for (int c = 0; c < `MM_B_COLS; c++) begin
            for (int k = 0; k < `MM_INNER; k++) begin
                new_cols[c][k] = elem_t'($urandom);
            end
        end
        base = done_count;
        pulse_start();
        // B reloads and a second start land while the FSM is computing
        for (int c = 0; c < `MM_B_COLS; c++) begin
            load.b_write = 1'b1;
            load.addr    = row_idx_t'(c);
            load.data    = new_cols[c];
            start        = (c == 1);
            next_cycle();
        end
        load  = '0;
        start = 1'b0;
        wait_done(base);
        if (timed_out) begin
            return;
        end
        repeat (16) next_cycle();
        if (done_count != base + 1) begin
            report_error("start during compute produced another done");
        end
        run_readout(1'b0);
        if (timed_out) begin
            return;
        end
        test_name = "reloaded_b";
        for (int c = 0; c < `MM_B_COLS; c++) begin
            for (int k = 0; k < `MM_INNER; k++) begin
                b_ref[c][k] = new_cols[c][k];
            end
        end
        write_operands();
        run_compute();
        if (timed_out) begin
            return;
        end
        run_readout(1'b0);
    endtask

    task automatic test_full_scale();
        test_name = "full_scale";
        for (int r = 0; r < `MM_A_ROWS; r++) begin
            for (int k = 0; k < `MM_INNER; k++) begin
                a_ref[r][k] = 8'hff;
                b_ref[r][k] = 8'hff;
            end
        end
        write_operands();
        run_compute();
        if (timed_out) begin
            return;
        end
        run_readout(1'b0);
        if (timed_out) begin
            return;
        end
        // largest possible dot product must survive in 20 bits
        for (int r = 0; r < `MM_A_ROWS; r++) begin
            for (int c = 0; c < `MM_B_COLS; c++) begin
                check_sum($sformatf("full_scale row %0d col %0d", r, c),
                          sum_t'(`MM_INNER * 255 * 255), got_rows[r].sums[c]);
            end
        end
    endtask

    initial begin
        void'($urandom(56452));
        resetn      = 1'b0;
        load        = '0;
        start       = 1'b0;
        read        = 1'b0;
        read_credit = 1'b0;
        repeat (5) next_cycle();
        resetn = 1'b1;
        test_reset_quiet();
        if (!timed_out) test_random_product();
        if (!timed_out) test_credit_backpressure();
        if (!timed_out) test_ignored_during_compute();
        if (!timed_out) test_full_scale();
        $display("error counts: %0d mismatches, %0d other errors, %0d timeouts",
                 mismatch_count, error_count, int'(timed_out));
        if (mismatch_count == 0 && error_count == 0 && !timed_out) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* mat_mult.f */
+incdir+src
+incdir+verif
src/mat_mult_pkg.sv
src/operand_store.sv
src/dot_product_lane.sv
src/mat_mult_sequencer.sv
src/result_store.sv
src/mat_mult_top.sv
verif/mat_mult_tb.sv

/* Makefile */
SRCS := $(wildcard src/*.sv src/*.svh verif/*.sv verif/*.svh)

.PHONY: run clean

run: obj_dir/Vmat_mult_tb
	@out="$$(./obj_dir/Vmat_mult_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

obj_dir/Vmat_mult_tb: mat_mult.f $(SRCS)
	verilator --binary --timing -f mat_mult.f --top-module mat_mult_tb

clean:
	rm -rf obj_dir
